//--- addrgen_pkg.sv
// Vector load/store address generator, shared definitions
// Address, length, stride and element-width types plus the
// AXI burst and page limits used by the burst engine
package addrgen_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Byte address bus
  localparam int unsigned AddrWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  // Element count of one vector request
  typedef logic [15:0]          vlen_t;
  // Byte stride between strided elements
  typedef logic [31:0]          stride_t;
  // Element width code, 0 = 8-bit up to 3 = 64-bit
  typedef logic [1:0]           ew_t;

  ////////////////////////////////////////////////////////////
  // AXI address channel fields and limits
  ////////////////////////////////////////////////////////////

  // AxLEN holds beats minus one
  typedef logic [7:0] axlen_t;
  // AxSIZE holds log2 of bytes per beat
  typedef logic [2:0] axsize_t;

  // Longest INCR burst
  localparam int unsigned MaxBurstBeats = 256;
  // Bursts must stay inside a 4 KiB page
  localparam int unsigned PageBits      = 12;

endpackage

//--- vreq_frontend.sv
// Request front end of the address generator
// Accepts one vector memory request, checks the base address
// against the element size and starts either the burst engine
// or the stride engine, then acknowledges when it finishes
`timescale 1ns/1ps

module vreq_frontend (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request handshake
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  addrgen_pkg::addr_t   req_addr_i,
  input  addrgen_pkg::vlen_t   req_len_i,
  input  addrgen_pkg::ew_t     req_ew_i,
  input  addrgen_pkg::stride_t req_stride_i,
  input  logic                 req_is_load_i,
  input  logic                 req_unit_stride_i,
  // Completion pulses
  output logic                 ack_o,
  output logic                 error_o,
  // Engine control
  output logic                 bs_start_o,
  output logic                 ss_start_o,
  input  logic                 bs_done_i,
  input  logic                 ss_done_i,
  // Registered job
  output addrgen_pkg::addr_t   job_addr_o,
  output addrgen_pkg::vlen_t   job_len_o,
  output addrgen_pkg::ew_t     job_ew_o,
  output addrgen_pkg::stride_t job_stride_o,
  output logic                 job_is_load_o
);

  typedef enum logic [1:0] {IDLE, CHECK, BUSY} state_e;

  state_e             state_q, state_d;
  logic               unit_stride_q;
  logic               done_ack_q;
  addrgen_pkg::addr_t elem_mask;
  logic               misaligned;

  assign req_ready_o = (state_q == IDLE);

  // Bits below the element size must all be zero
  assign elem_mask  = (addrgen_pkg::addr_t'(1) << job_ew_o) - addrgen_pkg::addr_t'(1);
  assign misaligned = |(job_addr_o & elem_mask);

  // Latch the request on acceptance
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      job_addr_o    <= req_addr_i;
      job_len_o     <= req_len_i;
      job_ew_o      <= req_ew_i;
      job_stride_o  <= req_stride_i;
      job_is_load_o <= req_is_load_i;
      unit_stride_q <= req_unit_stride_i;
    end
  end

  always_comb begin
    state_d    = state_q;
    bs_start_o = 1'b0;
    ss_start_o = 1'b0;
    error_o    = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_valid_i) state_d = CHECK;
      end
      CHECK: begin
        if (misaligned) begin
          // Misaligned base, report at once and drop the job
          error_o = 1'b1;
          state_d = IDLE;
        end else begin
          bs_start_o = unit_stride_q;
          ss_start_o = !unit_stride_q;
          state_d    = BUSY;
        end
      end
      BUSY: begin
        if (bs_done_i || ss_done_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  // Error ack comes straight from CHECK, normal ack one cycle after done
  assign ack_o = error_o | done_ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      done_ack_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      done_ack_q <= (state_q == BUSY) && (bs_done_i || ss_done_i);
    end
  end

  // Only one engine runs per job
  a_single_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bs_done_i && ss_done_i));

endmodule

//--- burst_splitter.sv
// Unit-stride burst engine
// Cuts a contiguous request into AXI INCR bursts of at most
// 256 bus words that never cross a 4 KiB page; each burst is
// planned in its own cycle and then held until granted
`timescale 1ns/1ps

module burst_splitter #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  addrgen_pkg::addr_t   addr_i,
  input  addrgen_pkg::vlen_t   len_i,
  input  addrgen_pkg::ew_t     ew_i,
  output logic                 beat_valid_o,
  output addrgen_pkg::addr_t   beat_addr_o,
  output addrgen_pkg::axlen_t  beat_len_o,
  output addrgen_pkg::axsize_t beat_size_o,
  input  logic                 grant_i,
  output logic                 done_o
);

  // Bus word size in bytes and its log2
  localparam int unsigned BusBytes = DataWidth / 8;
  localparam int unsigned BusLog   = $clog2(BusBytes);
  // Byte offset bits inside one bus word
  localparam addrgen_pkg::addr_t WordMask = addrgen_pkg::addr_t'(BusBytes - 1);

  typedef enum logic [1:0] {IDLE, PLAN, ISSUE} state_e;

  state_e               state_q, state_d;
  addrgen_pkg::addr_t   cur_addr_q;
  addrgen_pkg::addr_t   end_q;
  addrgen_pkg::vlen_t   rem_q;
  addrgen_pkg::ew_t     ew_q;
  addrgen_pkg::axlen_t  len_q;

  // Burst planning terms
  addrgen_pkg::addr_t   start_aligned;
  addrgen_pkg::addr_t   rem_bytes;
  addrgen_pkg::addr_t   end_data;
  addrgen_pkg::addr_t   end_max;
  addrgen_pkg::addr_t   end_page;
  addrgen_pkg::addr_t   end_plan;
  // Element accounting for the burst on the bus
  addrgen_pkg::addr_t   consumed;
  addrgen_pkg::vlen_t   rem_next;
  logic                 last_burst;
  addrgen_pkg::addr_t   burst_last;

  ////////////////////////////////////////////////////////////
  // Burst rule
  ////////////////////////////////////////////////////////////

  assign start_aligned = cur_addr_q & ~WordMask;
  assign rem_bytes     = addrgen_pkg::addr_t'(rem_q) << ew_q;

  // Last data byte rounded up to the end of its bus word
  assign end_data = (cur_addr_q + rem_bytes - 1) | WordMask;
  // Burst length limit
  assign end_max  = start_aligned + addrgen_pkg::addr_t'(addrgen_pkg::MaxBurstBeats * BusBytes) - 1;
  // Last byte of the current page
  assign end_page = cur_addr_q | addrgen_pkg::addr_t'((1 << addrgen_pkg::PageBits) - 1);

  // Smallest of the three limits
  always_comb begin
    end_plan = end_data;
    if (end_max < end_plan)  end_plan = end_max;
    if (end_page < end_plan) end_plan = end_page;
  end

  // Elements covered by the planned burst with the remainder saturating at zero
  assign consumed   = (end_q - cur_addr_q + 1) >> ew_q;
  assign rem_next   = (addrgen_pkg::addr_t'(rem_q) > consumed) ?
                      rem_q - addrgen_pkg::vlen_t'(consumed) : '0;
  assign last_burst = (rem_next == '0);

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = PLAN;
      PLAN:    state_d = ISSUE;
      ISSUE:   if (grant_i) state_d = last_burst ? IDLE : PLAN;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cur_addr_q <= addr_i;
      rem_q      <= len_i;
      ew_q       <= ew_i;
    end else if (state_q == ISSUE && grant_i) begin
      // Next burst starts right after this one
      cur_addr_q <= end_q + 1;
      rem_q      <= rem_next;
    end
    if (state_q == PLAN) begin
      end_q <= end_plan;
      // Beats minus one
      len_q <= addrgen_pkg::axlen_t'((end_plan - start_aligned) >> BusLog);
    end
  end

  assign beat_valid_o = (state_q == ISSUE);
  assign beat_addr_o  = cur_addr_q;
  assign beat_len_o   = len_q;
  assign beat_size_o  = addrgen_pkg::axsize_t'(BusLog);
  assign done_o       = (state_q == ISSUE) && grant_i && last_burst;

  // Last byte implied by address, AxLEN and AxSIZE
  assign burst_last = start_aligned + ((addrgen_pkg::addr_t'(len_q) + 1) << BusLog) - 1;

  a_no_page_cross: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid_o |-> beat_addr_o[addrgen_pkg::AddrWidth-1:addrgen_pkg::PageBits] ==
                     burst_last[addrgen_pkg::AddrWidth-1:addrgen_pkg::PageBits]);

endmodule

//--- stride_stepper.sv
// Strided access engine
// Emits one single-beat request per element, stepping the
// address by the byte stride on every grant
`timescale 1ns/1ps

module stride_stepper (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  addrgen_pkg::addr_t   addr_i,
  input  addrgen_pkg::vlen_t   len_i,
  input  addrgen_pkg::ew_t     ew_i,
  input  addrgen_pkg::stride_t stride_i,
  output logic                 beat_valid_o,
  output addrgen_pkg::addr_t   beat_addr_o,
  output addrgen_pkg::axlen_t  beat_len_o,
  output addrgen_pkg::axsize_t beat_size_o,
  input  logic                 grant_i,
  output logic                 done_o
);

  logic                 busy_q;
  addrgen_pkg::addr_t   addr_q;
  addrgen_pkg::vlen_t   cnt_q;
  addrgen_pkg::ew_t     ew_q;
  addrgen_pkg::stride_t stride_q;

  // Last element leaves with this grant
  assign done_o = busy_q && grant_i && (cnt_q == addrgen_pkg::vlen_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end
  end

  // Address and count step together so a grant can come every cycle
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= addr_i;
      cnt_q    <= len_i;
      ew_q     <= ew_i;
      stride_q <= stride_i;
    end else if (busy_q && grant_i) begin
      addr_q <= addr_q + addrgen_pkg::addr_t'(stride_q);
      cnt_q  <= cnt_q - 1'b1;
    end
  end

  // One element per beat, beat size is the element size
  assign beat_valid_o = busy_q;
  assign beat_addr_o  = addr_q;
  assign beat_len_o   = '0;
  assign beat_size_o  = addrgen_pkg::axsize_t'(ew_q);

endmodule

//--- ax_issue.sv
// Address channel issue stage
// Steers the active engine's beat onto AR or AW, mirrors every
// accepted beat as a command to the load/store units and keeps
// the command credits; a change of direction waits for all
// outstanding commands to drain
`timescale 1ns/1ps

module ax_issue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Burst engine
  input  logic                 bs_valid_i,
  input  addrgen_pkg::addr_t   bs_addr_i,
  input  addrgen_pkg::axlen_t  bs_len_i,
  input  addrgen_pkg::axsize_t bs_size_i,
  output logic                 bs_grant_o,
  // Stride engine
  input  logic                 ss_valid_i,
  input  addrgen_pkg::addr_t   ss_addr_i,
  input  addrgen_pkg::axlen_t  ss_len_i,
  input  addrgen_pkg::axsize_t ss_size_i,
  output logic                 ss_grant_o,
  input  logic                 is_load_i,
  // AXI read address
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output addrgen_pkg::addr_t   ar_addr_o,
  output addrgen_pkg::axlen_t  ar_len_o,
  output addrgen_pkg::axsize_t ar_size_o,
  // AXI write address
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  output addrgen_pkg::addr_t   aw_addr_o,
  output addrgen_pkg::axlen_t  aw_len_o,
  output addrgen_pkg::axsize_t aw_size_o,
  // Load/store unit commands
  output logic                 cmd_valid_o,
  output addrgen_pkg::addr_t   cmd_addr_o,
  output addrgen_pkg::axlen_t  cmd_len_o,
  output addrgen_pkg::axsize_t cmd_size_o,
  output logic                 cmd_is_load_o,
  input  logic                 cmd_credit_i
);

  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  logic [CntWidth-1:0]  credit_q, credit_d;
  logic                 dir_is_load_q;
  logic                 sel_valid;
  addrgen_pkg::addr_t   sel_addr;
  addrgen_pkg::axlen_t  sel_len;
  addrgen_pkg::axsize_t sel_size;
  logic                 all_back;
  logic                 may_issue;
  logic                 send;

  // At most one engine is active, pick its beat
  assign sel_valid = bs_valid_i | ss_valid_i;
  assign sel_addr  = bs_valid_i ? bs_addr_i : ss_addr_i;
  assign sel_len   = bs_valid_i ? bs_len_i : ss_len_i;
  assign sel_size  = bs_valid_i ? bs_size_i : ss_size_i;

  // Needs a credit, and same direction unless everything returned
  assign all_back  = (credit_q == CntWidth'(QueueDepth));
  assign may_issue = (credit_q != '0) && (all_back || (dir_is_load_q == is_load_i));

  ////////////////////////////////////////////////////////////
  // Channel steering
  ////////////////////////////////////////////////////////////

  assign ar_valid_o = sel_valid && is_load_i && may_issue;
  assign ar_addr_o  = sel_addr;
  assign ar_len_o   = sel_len;
  assign ar_size_o  = sel_size;

  assign aw_valid_o = sel_valid && !is_load_i && may_issue;
  assign aw_addr_o  = sel_addr;
  assign aw_len_o   = sel_len;
  assign aw_size_o  = sel_size;

  assign send = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  // Grant and command go out with the channel handshake
  assign bs_grant_o    = send && bs_valid_i;
  assign ss_grant_o    = send && !bs_valid_i;
  assign cmd_valid_o   = send;
  assign cmd_addr_o    = sel_addr;
  assign cmd_len_o     = sel_len;
  assign cmd_size_o    = sel_size;
  assign cmd_is_load_o = is_load_i;

  ////////////////////////////////////////////////////////////
  // Credits and direction
  ////////////////////////////////////////////////////////////

  always_comb begin
    credit_d = credit_q;
    if (cmd_credit_i && !send) begin
      credit_d = credit_q + 1'b1;
    end else if (send && !cmd_credit_i) begin
      credit_d = credit_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q      <= CntWidth'(QueueDepth);
      dir_is_load_q <= 1'b1;
    end else begin
      credit_q <= credit_d;
      if (send) dir_is_load_q <= is_load_i;
    end
  end

  // Units never return more credits than were spent
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CntWidth'(QueueDepth));

  a_one_engine: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bs_valid_i && ss_valid_i));

endmodule

//--- addrgen_top.sv
// Vector load/store address generator, top level
// Front end feeds a burst engine and a stride engine side by
// side; the issue stage merges their beats onto AR/AW and the
// load/store command port
`timescale 1ns/1ps

module addrgen_top #(
  parameter int unsigned DataWidth  = 64,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  addrgen_pkg::addr_t   req_addr_i,
  input  addrgen_pkg::vlen_t   req_len_i,
  input  addrgen_pkg::ew_t     req_ew_i,
  input  addrgen_pkg::stride_t req_stride_i,
  input  logic                 req_is_load_i,
  input  logic                 req_unit_stride_i,
  output logic                 ack_o,
  output logic                 error_o,
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output addrgen_pkg::addr_t   ar_addr_o,
  output addrgen_pkg::axlen_t  ar_len_o,
  output addrgen_pkg::axsize_t ar_size_o,
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  output addrgen_pkg::addr_t   aw_addr_o,
  output addrgen_pkg::axlen_t  aw_len_o,
  output addrgen_pkg::axsize_t aw_size_o,
  output logic                 cmd_valid_o,
  output addrgen_pkg::addr_t   cmd_addr_o,
  output addrgen_pkg::axlen_t  cmd_len_o,
  output addrgen_pkg::axsize_t cmd_size_o,
  output logic                 cmd_is_load_o,
  input  logic                 cmd_credit_i
);

  // Job from the front end
  addrgen_pkg::addr_t   job_addr;
  addrgen_pkg::vlen_t   job_len;
  addrgen_pkg::ew_t     job_ew;
  addrgen_pkg::stride_t job_stride;
  logic                 job_is_load;
  logic                 bs_start, ss_start, bs_done, ss_done;
  // Engine beats
  logic                 bs_valid, ss_valid, bs_grant, ss_grant;
  addrgen_pkg::addr_t   bs_addr, ss_addr;
  addrgen_pkg::axlen_t  bs_len, ss_len;
  addrgen_pkg::axsize_t bs_size, ss_size;

  vreq_frontend u_frontend (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_addr_i, .req_len_i, .req_ew_i,
    .req_stride_i, .req_is_load_i, .req_unit_stride_i,
    .ack_o, .error_o,
    .bs_start_o   (bs_start),
    .ss_start_o   (ss_start),
    .bs_done_i    (bs_done),
    .ss_done_i    (ss_done),
    .job_addr_o   (job_addr),
    .job_len_o    (job_len),
    .job_ew_o     (job_ew),
    .job_stride_o (job_stride),
    .job_is_load_o(job_is_load)
  );

  burst_splitter #(
    .DataWidth(DataWidth)
  ) u_burst (
    .clk_i, .rst_ni,
    .start_i     (bs_start),
    .addr_i      (job_addr),
    .len_i       (job_len),
    .ew_i        (job_ew),
    .beat_valid_o(bs_valid),
    .beat_addr_o (bs_addr),
    .beat_len_o  (bs_len),
    .beat_size_o (bs_size),
    .grant_i     (bs_grant),
    .done_o      (bs_done)
  );

  stride_stepper u_stride (
    .clk_i, .rst_ni,
    .start_i     (ss_start),
    .addr_i      (job_addr),
    .len_i       (job_len),
    .ew_i        (job_ew),
    .stride_i    (job_stride),
    .beat_valid_o(ss_valid),
    .beat_addr_o (ss_addr),
    .beat_len_o  (ss_len),
    .beat_size_o (ss_size),
    .grant_i     (ss_grant),
    .done_o      (ss_done)
  );

  ax_issue #(
    .QueueDepth(QueueDepth)
  ) u_issue (
    .clk_i, .rst_ni,
    .bs_valid_i(bs_valid), .bs_addr_i(bs_addr), .bs_len_i(bs_len),
    .bs_size_i (bs_size),  .bs_grant_o(bs_grant),
    .ss_valid_i(ss_valid), .ss_addr_i(ss_addr), .ss_len_i(ss_len),
    .ss_size_i (ss_size),  .ss_grant_o(ss_grant),
    .is_load_i (job_is_load),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o,
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o, .aw_size_o,
    .cmd_valid_o, .cmd_addr_o, .cmd_len_o, .cmd_size_o, .cmd_is_load_o,
    .cmd_credit_i
  );

endmodule

//--- tb_addrgen.sv
// Directed testbench for the vector load/store address generator
// Drives requests on falling edges, models random AXI ready and a
// load/store unit that returns command credits a few cycles late,
// and checks every beat against the burst and stride rules
`timescale 1ns/1ps

module tb_addrgen;

  localparam int DataWidth    = 64;
  localparam int QueueDepth   = 4;
  localparam int BusLog       = $clog2(DataWidth / 8);
  localparam int HoldCycles   = 30;
  localparam int ReqCycles    = 300;
  localparam int NumRequests  = 9;
  // Every request gets its own allowance plus the three hold windows
  localparam int BudgetCycles = NumRequests * ReqCycles + 3 * HoldCycles + 500;
  localparam logic [63:0] BusBytes = 64'(DataWidth / 8);
  localparam logic [63:0] PageSize = 64'(1) << addrgen_pkg::PageBits;
  localparam logic [63:0] MaxBeats = 64'(addrgen_pkg::MaxBurstBeats);

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_valid_i, req_ready_o, req_is_load_i, req_unit_stride_i;
  addrgen_pkg::addr_t   req_addr_i;
  addrgen_pkg::vlen_t   req_len_i;
  addrgen_pkg::ew_t     req_ew_i;
  addrgen_pkg::stride_t req_stride_i;
  logic ack_o, error_o;
  logic ar_valid_o, aw_valid_o, cmd_valid_o, cmd_is_load_o;
  logic ar_ready_i = 1'b0;
  logic aw_ready_i = 1'b0;
  logic cmd_credit_i = 1'b0;
  addrgen_pkg::addr_t   ar_addr_o, aw_addr_o, cmd_addr_o;
  addrgen_pkg::axlen_t  ar_len_o, aw_len_o, cmd_len_o;
  addrgen_pkg::axsize_t ar_size_o, aw_size_o, cmd_size_o;

  // Beat records {is_load, addr, len, size} zero padded to 64 bits
  logic [63:0] exp_q[$];
  logic [63:0] beat_q[$];
  logic [63:0] cmd_q[$];
  int          due_q[$];
  logic        pend_q[$];
  int beat_base = 0, cmd_base = 0, due_idx = 0, cyc = 0;
  int n_loads = 0, n_stores = 0, max_out = 0, dir_violations = 0;
  int check_errs = 0, other_errs = 0;
  integer seed = 32'he3d8ff4c;
  logic [31:0] rnd;
  logic hold_credits;
  logic err;

  always #4 clk_i = ~clk_i;

  addrgen_top #(.DataWidth(DataWidth), .QueueDepth(QueueDepth)) DUT (.*);

  ////////////////////////////////////////////////////////////
  // Memory side models
  ////////////////////////////////////////////////////////////

  // Record AR/AW transfers and commands at the rising edge
  always @(posedge clk_i) begin
    cyc++;
    // Direction rule seen from the outstanding commands before this edge
    if (ar_valid_o && ar_ready_i) begin
      if (n_stores != 0) dir_violations++;
      beat_q.push_back({20'd0, 1'b1, ar_addr_o, ar_len_o, ar_size_o});
    end
    if (aw_valid_o && aw_ready_i) begin
      if (n_loads != 0) dir_violations++;
      beat_q.push_back({20'd0, 1'b0, aw_addr_o, aw_len_o, aw_size_o});
    end
    if (cmd_credit_i) begin
      if (pend_q.pop_front()) n_loads--;
      else n_stores--;
    end
    if (cmd_valid_o) begin
      cmd_q.push_back({20'd0, cmd_is_load_o, cmd_addr_o, cmd_len_o, cmd_size_o});
      pend_q.push_back(cmd_is_load_o);
      due_q.push_back(cyc + 3);
      if (cmd_is_load_o) n_loads++;
      else n_stores++;
    end
    if (pend_q.size() > max_out) max_out = pend_q.size();
  end

  // Random channel ready and an LSU that returns one credit per cycle when due
  always @(negedge clk_i) begin
    rnd = $random(seed);
    ar_ready_i = rnd[0];
    aw_ready_i = rnd[1];
    if (!hold_credits && due_idx < due_q.size() && due_q[due_idx] <= cyc) begin
      cmd_credit_i = 1'b1;
      due_idx++;
    end else begin
      cmd_credit_i = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checking and expected beats
  ////////////////////////////////////////////////////////////

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      check_errs++;
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Page-safe INCR bursts whose end is the nearest of data, length and page limit
  task automatic expect_bursts(input logic [63:0] addr, input logic [63:0] len,
                               input logic [63:0] ew, input logic is_load);
    logic [63:0] cur, rem, aligned, e, lim, axlen, consumed;
    cur = addr;
    rem = len;
    while (rem != 64'd0) begin
      aligned = cur - (cur % BusBytes);
      e = ((cur + (rem << ew) - 64'd1) / BusBytes) * BusBytes + BusBytes - 64'd1;
      lim = aligned + MaxBeats * BusBytes - 64'd1;
      if (lim < e) e = lim;
      lim = (cur / PageSize) * PageSize + PageSize - 64'd1;
      if (lim < e) e = lim;
      axlen = (e - aligned + 64'd1) / BusBytes - 64'd1;
      exp_q.push_back({20'd0, is_load, 32'(cur), 8'(axlen), 3'(BusLog)});
      consumed = (e - cur + 64'd1) >> ew;
      rem = (rem > consumed) ? rem - consumed : 64'd0;
      cur = e + 64'd1;
    end
  endtask

  task automatic build_expect(input addrgen_pkg::addr_t addr, input addrgen_pkg::vlen_t len,
                              input addrgen_pkg::ew_t ew, input addrgen_pkg::stride_t stride,
                              input logic is_load, input logic unit);
    logic [31:0] a;
    int i;
    if (unit) begin
      expect_bursts(64'(addr), 64'(len), 64'(ew), is_load);
    end else begin
      // One single-beat request per element at base plus i times stride
      a = addr;
      for (i = 0; i < 32'(len); i++) begin
        exp_q.push_back({20'd0, is_load, a, 8'd0, 1'b0, ew});
        a = a + stride;
      end
    end
  endtask

  task automatic compare_beats(input string name);
    int i;
    check_value(64'(beat_q.size() - beat_base), 64'(exp_q.size()), {name, " AR/AW count"});
    check_value(64'(cmd_q.size() - cmd_base), 64'(exp_q.size()), {name, " command count"});
    for (i = 0; i < exp_q.size(); i++) begin
      check_value(beat_q[beat_base + i], exp_q[i], $sformatf("%s beat %0d", name, i));
      check_value(cmd_q[cmd_base + i], exp_q[i], $sformatf("%s command %0d", name, i));
    end
    exp_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Request driving
  ////////////////////////////////////////////////////////////

  task automatic start_job(input addrgen_pkg::addr_t addr, input addrgen_pkg::vlen_t len,
                           input addrgen_pkg::ew_t ew, input addrgen_pkg::stride_t stride,
                           input logic is_load, input logic unit);
    int n;
    beat_base = beat_q.size();
    cmd_base  = cmd_q.size();
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_addr_i = addr;
    req_len_i = len;
    req_ew_i = ew;
    req_stride_i = stride;
    req_is_load_i = is_load;
    req_unit_stride_i = unit;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!req_ready_o && n < ReqCycles);
    if (!req_ready_o) begin
      other_errs++;
      $display("Request at %h was never accepted", addr);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_ack(output logic err_o);
    int n;
    bit seen;
    seen = 1'b0;
    err_o = 1'b0;
    for (n = 0; n < ReqCycles && !seen; n++) begin
      @(posedge clk_i);
      if (ack_o) begin
        seen = 1'b1;
        err_o = error_o;
      end
    end
    if (!seen) begin
      other_errs++;
      $display("No acknowledge within %0d cycles at time %0t", ReqCycles, $time);
    end
  endtask

  task automatic run_job(input string name, input addrgen_pkg::addr_t addr,
                         input addrgen_pkg::vlen_t len, input addrgen_pkg::ew_t ew,
                         input addrgen_pkg::stride_t stride, input logic is_load,
                         input logic unit);
    build_expect(addr, len, ew, stride, is_load, unit);
    start_job(addr, len, ew, stride, is_load, unit);
    wait_ack(err);
    check_value(64'(err), 64'd0, {name, " error flag"});
    compare_beats(name);
  endtask

  // Wait for all credits, then freeze returns from the next edge on
  task automatic drain_and_hold();
    int n;
    for (n = 0; n < ReqCycles && pend_q.size() != 0; n++) @(negedge clk_i);
    if (pend_q.size() != 0) begin
      other_errs++;
      $display("Command credits were not returned within %0d cycles", ReqCycles);
    end
    @(posedge clk_i);
    hold_credits = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic misaligned_error();
    start_job(32'h1002, 16'd4, 2'd2, 32'd0, 1'b1, 1'b1);
    wait_ack(err);
    check_value(64'(err), 64'd1, "misaligned error flag");
    // An engine started by mistake would reach the bus within this window
    repeat (HoldCycles) @(negedge clk_i);
    check_value(64'(beat_q.size() - beat_base), 64'd0, "misaligned AR/AW count");
    check_value(64'(cmd_q.size() - cmd_base), 64'd0, "misaligned command count");
  endtask

  task automatic page_cross_store();
    logic [63:0] total;
    int i;
    run_job("page cross store", 32'h3FF0, 16'd8, 2'd3, 32'd0, 1'b0, 1'b1);
    check_value(64'(beat_q[beat_base + 1][42:11]), 64'h4000, "second burst address");
    total = 64'd0;
    for (i = beat_base; i < beat_q.size(); i++) total = total + 64'(beat_q[i][10:3]) + 64'd1;
    check_value(total * BusBytes, 64'd64, "page cross bytes covered");
  endtask

  task automatic credit_limit_load();
    drain_and_hold();
    build_expect(32'h8000, 16'd6, 2'd1, 32'd6, 1'b1, 1'b0);
    start_job(32'h8000, 16'd6, 2'd1, 32'd6, 1'b1, 1'b0);
    repeat (HoldCycles) @(negedge clk_i);
    check_value(64'(cmd_q.size() - cmd_base), 64'(QueueDepth), "commands with credits held");
    check_value(64'(max_out), 64'(QueueDepth), "peak outstanding commands");
    @(posedge clk_i);
    hold_credits = 1'b0;
    wait_ack(err);
    check_value(64'(err), 64'd0, "credit limited load error flag");
    compare_beats("credit limited load");
  endtask

  task automatic store_after_load();
    drain_and_hold();
    run_job("held load", 32'h9000, 16'd2, 2'd2, 32'd4, 1'b1, 1'b0);
    // Store must wait although two credits are still free
    build_expect(32'h9100, 16'd4, 2'd3, 32'd0, 1'b0, 1'b1);
    start_job(32'h9100, 16'd4, 2'd3, 32'd0, 1'b0, 1'b1);
    repeat (HoldCycles) @(negedge clk_i);
    check_value(64'(beat_q.size() - beat_base), 64'd0, "AW while loads outstanding");
    @(posedge clk_i);
    hold_credits = 1'b0;
    wait_ack(err);
    check_value(64'(err), 64'd0, "store after load error flag");
    compare_beats("store after load");
    check_value(64'(dir_violations), 64'd0, "direction ordering");
  endtask

  // Watchdog
  initial begin
    repeat (BudgetCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", BudgetCycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    hold_credits = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    req_len_i = '0;
    req_ew_i = '0;
    req_stride_i = '0;
    req_is_load_i = 1'b0;
    req_unit_stride_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value(64'(req_ready_o), 64'd1, "ready after reset");
    check_value(64'({ar_valid_o, aw_valid_o, cmd_valid_o, ack_o, error_o}), 64'd0,
                "outputs idle after reset");
    misaligned_error();
    run_job("short load", 32'h2004, 16'd10, 2'd2, 32'd0, 1'b1, 1'b1);
    page_cross_store();
    run_job("long load", 32'h10000, 16'd600, 2'd3, 32'd0, 1'b1, 1'b1);
    run_job("strided load", 32'h5000, 16'd5, 2'd2, 32'd12, 1'b1, 1'b0);
    run_job("strided store", 32'h6100, 16'd4, 2'd3, 32'hFFFF_FFF8, 1'b0, 1'b0);
    credit_limit_load();
    store_after_load();
    $display("Summary: %0d check errors, %0d other errors", check_errs, other_errs);
    if (check_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- list.f
addrgen_pkg.sv
vreq_frontend.sv
burst_splitter.sv
stride_stepper.sv
ax_issue.sv
addrgen_top.sv
tb_addrgen.sv

//--- run.sh
#!/bin/sh
# Compile and run the address generator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_addrgen -f list.f -o sim_addrgen
./obj_dir/sim_addrgen > sim.log
cat sim.log
if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
